// File: datapath.f
design/datapathPkg.sv
design/aluSlice.sv
design/carryLookahead.sv
design/statusShift.sv
design/datapath.sv
tb/clockGen.sv
tb/datapathTb.sv

// File: design/aluSlice.sv
`timescale 1ns/100ps

module aluSlice (
    input  logic                   clk,
    input  logic                   arstN,
    input  datapathPkg::aluInstrT  Ialu,
    input  datapathPkg::regAddrT   A,
    input  datapathPkg::regAddrT   B,
    input  datapathPkg::nibbleT    D,
    input  logic                   C0,
    input  logic                   ram0In,   // Fill for bit 0 on up shift
    input  logic                   ram3In,   // Fill for bit 3 on down shift
    input  logic                   q0In,
    input  logic                   q3In,
    output datapathPkg::nibbleT    Y,
    output logic                   ram0Out,
    output logic                   ram3Out,
    output logic                   q0Out,
    output logic                   q3Out,
    output logic                   nG,
    output logic                   nP,
    output logic                   C4,
    output logic                   OVR,
    output logic                   F3,
    output logic                   Z
);

    datapathPkg::nibbleT regFile [16];
    datapathPkg::nibbleT qData;
    datapathPkg::nibbleT aData, bData;
    datapathPkg::nibbleT rOp, sOp;
    datapathPkg::nibbleT rEff, sEff;
    datapathPkg::nibbleT F;
    datapathPkg::nibbleT ramNext, qNext;
    logic [2:0] src, func, dest;
    logic [4:0] sum;
    logic [3:0] lowSum;
    logic [3:0] gen, prop;
    logic       arith;
    logic       ramWrite, qWrite;

    assign src  = Ialu[2:0];
    assign func = Ialu[5:3];
    assign dest = Ialu[8:6];

    // Two read ports, both asynchronous
    assign aData = regFile[A];
    assign bData = regFile[B];

    // Operand selection, standard Am2901 source table
    always_comb begin
        case (src)
            3'd0:    begin rOp = aData; sOp = qData; end  // AQ
            3'd1:    begin rOp = aData; sOp = bData; end  // AB
            3'd2:    begin rOp = '0;    sOp = qData; end  // ZQ
            3'd3:    begin rOp = '0;    sOp = bData; end  // ZB
            3'd4:    begin rOp = '0;    sOp = aData; end  // ZA
            3'd5:    begin rOp = D;     sOp = aData; end  // DA
            3'd6:    begin rOp = D;     sOp = qData; end  // DQ
            default: begin rOp = D;     sOp = '0;    end  // DZ
        endcase
    end

    // Subtracts invert one operand and rely on carry in
    assign arith = (func == datapathPkg::add) || (func == datapathPkg::subR) ||
                   (func == datapathPkg::subS);
    assign rEff  = (func == datapathPkg::subR) ? ~rOp : rOp;
    assign sEff  = (func == datapathPkg::subS) ? ~sOp : sOp;

    assign sum    = {1'b0, rEff} + {1'b0, sEff} + {4'b0, C0};
    assign lowSum = {1'b0, rEff[2:0]} + {1'b0, sEff[2:0]} + {3'b0, C0};

    always_comb begin
        case (func)
            datapathPkg::orOp:     F = rOp | sOp;
            datapathPkg::andOp:    F = rOp & sOp;
            datapathPkg::notRsAnd: F = ~rOp & sOp;
            datapathPkg::exor:     F = rOp ^ sOp;
            datapathPkg::exnor:    F = ~(rOp ^ sOp);
            default:               F = sum[3:0];
        endcase
    end

    // Lookahead terms; logic functions report no generate or propagate,
    // so carry and overflow read zero for them
    assign gen  = arith ? (rEff & sEff) : 4'b0;
    assign prop = arith ? (rEff | sEff) : 4'b0;
    assign nP   = ~(&prop);
    assign nG   = ~(gen[3] | (prop[3] & gen[2]) | (prop[3] & prop[2] & gen[1]) |
                    (prop[3] & prop[2] & prop[1] & gen[0]));

    assign C4  = arith & sum[4];
    assign OVR = arith & (sum[4] ^ lowSum[3]);
    assign F3  = F[3];
    assign Z   = (F == 4'b0);

    // Y shows the A port only for ramA
    assign Y = (dest == datapathPkg::ramA) ? aData : F;

    // Shift ends are always driven; neighbours pick what they need
    assign ram0Out = F[0];
    assign ram3Out = F[3];
    assign q0Out   = qData[0];
    assign q3Out   = qData[3];

    // Write data per destination
    always_comb begin
        ramNext  = F;
        qNext    = F;
        ramWrite = 1'b0;
        qWrite   = 1'b0;
        case (dest)
            datapathPkg::qReg: qWrite = 1'b1;
            datapathPkg::ramA, datapathPkg::ramF: ramWrite = 1'b1;
            datapathPkg::ramQd: begin
                ramNext  = {ram3In, F[3:1]};
                qNext    = {q3In, qData[3:1]};
                ramWrite = 1'b1;
                qWrite   = 1'b1;
            end
            datapathPkg::ramD: begin
                ramNext  = {ram3In, F[3:1]};
                ramWrite = 1'b1;
            end
            datapathPkg::ramQu: begin
                ramNext  = {F[2:0], ram0In};
                qNext    = {qData[2:0], q0In};
                ramWrite = 1'b1;
                qWrite   = 1'b1;
            end
            datapathPkg::ramU: begin
                ramNext  = {F[2:0], ram0In};
                ramWrite = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 16; i++) begin
                regFile[i] <= '0;
            end
        end else if (ramWrite) begin
            regFile[B] <= ramNext;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            qData <= '0;
        end else if (qWrite) begin
            qData <= qNext;
        end
    end

    // Ripple carry out of the adder agrees with the lookahead terms
    assert property (@(posedge clk) disable iff (!arstN)
        C4 == (~nG | (~nP & C0)))
        else $error("aluSlice: carry out disagrees with generate and propagate");

endmodule

// File: design/carryLookahead.sv
`timescale 1ns/100ps

module carryLookahead (
    input  logic Cn,
    input  logic nG0,
    input  logic nP0,
    input  logic nG1,
    input  logic nP1,
    input  logic nG2,
    input  logic nP2,
    input  logic nG3,
    input  logic nP3,
    output logic Cnx,  // Carry into group 1
    output logic Cny,  // Carry into group 2
    output logic Cnz,  // Carry into group 3
    output logic nG,   // Block generate, active low
    output logic nP    // Block propagate, active low
);

    logic g0, g1, g2, g3;
    logic p0, p1, p2, p3;

    // Work in active-high terms
    assign g0 = ~nG0;
    assign g1 = ~nG1;
    assign g2 = ~nG2;
    assign g3 = ~nG3;
    assign p0 = ~nP0;
    assign p1 = ~nP1;
    assign p2 = ~nP2;
    assign p3 = ~nP3;

    // Am2902 equations, no state
    assign Cnx = g0 | (p0 & Cn);
    assign Cny = g1 | (p1 & g0) | (p1 & p0 & Cn);
    assign Cnz = g2 | (p2 & g1) | (p2 & p1 & g0) | (p2 & p1 & p0 & Cn);

    assign nG = ~(g3 | (p3 & g2) | (p3 & p2 & g1) | (p3 & p2 & p1 & g0));
    assign nP = ~(p3 & p2 & p1 & p0);

endmodule

// File: design/datapath.sv
`timescale 1ns/100ps

module datapath (
    input  logic                      clk,
    input  logic                      arstN,
    input  datapathPkg::aluInstrT     Ialu,
    input  datapathPkg::regAddrT      A,
    input  datapathPkg::regAddrT      B,
    input  datapathPkg::wordT         D,
    input  logic                      C0,
    input  logic                      mode32,  // Flags from bit 31
    output datapathPkg::wordT         oYalu,
    input  datapathPkg::statusInstrT  Iss,
    input  logic                      nCEM,
    input  logic                      nCEN,
    output datapathPkg::flagsT        oYss,
    output logic                      CT,
    output logic                      Css
);

    localparam int n = datapathPkg::sliceCount;

    // Per-slice carry in, lookahead terms and flags
    logic [n-1:0] carry;
    logic [n-1:0] sliceNG, sliceNP;
    logic [n-1:0] sliceC4, sliceOvr, sliceSign, sliceZ;

    // Shift ends out of each slice, and fills into each slice
    logic [n-1:0] ramLo, ramHi, qLo, qHi;
    logic [n-1:0] ramIn0, ramIn3, qIn0, qIn3;

    // Second level lookahead
    logic [3:0] groupCarry;
    logic [3:0] groupNG, groupNP;

    logic c32, c64;
    logic C, V, N, Z;
    logic PR0, PQ0, PR63, PQ63;
    logic oR0, oQ0, oR63, oQ63;

    // Down shift takes bit 3 fill from the slice above, up shift
    // takes bit 0 fill from the slice below
    assign ramIn3 = {PR63, ramLo[n-1:1]};
    assign qIn3   = {PQ63, qLo[n-1:1]};
    assign ramIn0 = {ramHi[n-2:0], PR0};
    assign qIn0   = {qHi[n-2:0], PQ0};

    assign oR0  = ramLo[0];
    assign oQ0  = qLo[0];
    assign oR63 = ramHi[n-1];
    assign oQ63 = qHi[n-1];

    genvar i;
    generate
        for (i = 0; i < n; i++) begin : gSlice
            aluSlice slice_i (
                .clk     (clk),
                .arstN   (arstN),
                .Ialu    (Ialu),
                .A       (A),
                .B       (B),
                .D       (D[4*i +: 4]),
                .C0      (carry[i]),
                .ram0In  (ramIn0[i]),
                .ram3In  (ramIn3[i]),
                .q0In    (qIn0[i]),
                .q3In    (qIn3[i]),
                .Y       (oYalu[4*i +: 4]),
                .ram0Out (ramLo[i]),
                .ram3Out (ramHi[i]),
                .q0Out   (qLo[i]),
                .q3Out   (qHi[i]),
                .nG      (sliceNG[i]),
                .nP      (sliceNP[i]),
                .C4      (sliceC4[i]),
                .OVR     (sliceOvr[i]),
                .F3      (sliceSign[i]),
                .Z       (sliceZ[i])
            );
        end

        // One lookahead unit per group of four slices
        for (i = 0; i < 4; i++) begin : gGroup
            assign carry[4*i] = groupCarry[i];
            carryLookahead groupLa_i (
                .Cn  (groupCarry[i]),
                .nG0 (sliceNG[4*i]),
                .nP0 (sliceNP[4*i]),
                .nG1 (sliceNG[4*i+1]),
                .nP1 (sliceNP[4*i+1]),
                .nG2 (sliceNG[4*i+2]),
                .nP2 (sliceNP[4*i+2]),
                .nG3 (sliceNG[4*i+3]),
                .nP3 (sliceNP[4*i+3]),
                .Cnx (carry[4*i+1]),
                .Cny (carry[4*i+2]),
                .Cnz (carry[4*i+3]),
                .nG  (groupNG[i]),
                .nP  (groupNP[i])
            );
        end
    endgenerate

    // Second level feeds groups 1 to 3
    assign groupCarry[0] = C0;
    carryLookahead topLa_i (
        .Cn  (C0),
        .nG0 (groupNG[0]),
        .nP0 (groupNP[0]),
        .nG1 (groupNG[1]),
        .nP1 (groupNP[1]),
        .nG2 (groupNG[2]),
        .nP2 (groupNP[2]),
        .nG3 (groupNG[3]),
        .nP3 (groupNP[3]),
        .Cnx (groupCarry[1]),
        .Cny (groupCarry[2]),
        .Cnz (groupCarry[3]),
        .nG  (),
        .nP  ()
    );

    // Carry out of bit 31 is the carry into slice 8
    assign c32 = groupCarry[2];
    assign c64 = sliceC4[n-1];

    // Flags come from slice 7 or slice 15
    assign Z = mode32 ? (&sliceZ[7:0]) : (&sliceZ);
    assign N = mode32 ? sliceSign[7] : sliceSign[n-1];
    assign V = mode32 ? sliceOvr[7] : sliceOvr[n-1];
    assign C = mode32 ? c32 : c64;

    // D bits 3..0 feed the status bus in flagsT order
    statusShift status_i (
        .clk       (clk),
        .arstN     (arstN),
        .Iss       (Iss),
        .nCEM      (nCEM),
        .nCEN      (nCEN),
        .C         (C),
        .V         (V),
        .N         (N),
        .Z         (Z),
        .yIn       (D[3:0]),
        .nSE       (~Ialu[8]),  // Only destinations 4..7 shift
        .R0        (oR0),
        .R63       (oR63),
        .Q0        (oQ0),
        .Q63       (oQ63),
        .yOut      (oYss),
        .CT        (CT),
        .Css       (Css),
        .ramLowIn  (PR0),
        .ramHighIn (PR63),
        .qLowIn    (PQ0),
        .qHighIn   (PQ63)
    );

endmodule

// File: design/datapathPkg.sv
package datapathPkg;

    // Number of 4-bit slices across the 64-bit word
    localparam int sliceCount = 16;

    // Data word on D and oYalu
    typedef logic [63:0] wordT;

    // One slice worth of data
    typedef logic [3:0] nibbleT;

    // Register file address for the A and B ports
    typedef logic [3:0] regAddrT;

    // ALU microinstruction
    // Bits 2..0 source, 5..3 function, 8..6 destination
    typedef logic [8:0] aluInstrT;

    // Status and shift microinstruction
    typedef logic [12:0] statusInstrT;

    // Status nibble
    // Bit 0 zero, bit 1 negative, bit 2 overflow, bit 3 carry
    typedef logic [3:0] flagsT;

    // Field offsets inside statusInstrT
    localparam int condSelLo   = 0;   // 4 bits
    localparam int shiftLinkLo = 4;   // 3 bits
    localparam int carrySelLo  = 7;   // 2 bits
    localparam int microSrcLo  = 9;   // 2 bits
    localparam int ySelLo      = 11;  // 2 bits

    // ALU function codes, Ialu bits 5..3
    localparam logic [2:0] add      = 3'd0;  // R plus S
    localparam logic [2:0] subR     = 3'd1;  // S minus R
    localparam logic [2:0] subS     = 3'd2;  // R minus S
    localparam logic [2:0] orOp     = 3'd3;
    localparam logic [2:0] andOp    = 3'd4;
    localparam logic [2:0] notRsAnd = 3'd5;  // not R and S
    localparam logic [2:0] exor     = 3'd6;
    localparam logic [2:0] exnor    = 3'd7;

    // Destination codes, Ialu bits 8..6
    localparam logic [2:0] qReg  = 3'd0;  // F to Q
    localparam logic [2:0] nop   = 3'd1;
    localparam logic [2:0] ramA  = 3'd2;  // F to B, Y shows A port
    localparam logic [2:0] ramF  = 3'd3;  // F to B
    localparam logic [2:0] ramQd = 3'd4;  // F/2 to B, Q/2 to Q
    localparam logic [2:0] ramD  = 3'd5;  // F/2 to B
    localparam logic [2:0] ramQu = 3'd6;  // 2F to B, 2Q to Q
    localparam logic [2:0] ramU  = 3'd7;  // 2F to B

endpackage

// File: design/statusShift.sv
`timescale 1ns/100ps

module statusShift (
    input  logic                      clk,
    input  logic                      arstN,
    input  datapathPkg::statusInstrT  Iss,
    input  logic                      nCEM,
    input  logic                      nCEN,
    input  logic                      C,
    input  logic                      V,
    input  logic                      N,
    input  logic                      Z,
    input  datapathPkg::flagsT        yIn,
    input  logic                      nSE,
    input  logic                      R0,
    input  logic                      R63,
    input  logic                      Q0,
    input  logic                      Q63,
    output datapathPkg::flagsT        yOut,
    output logic                      CT,
    output logic                      Css,
    output logic                      ramLowIn,   // Fill for bit 0 on up shift
    output logic                      ramHighIn,  // Fill for bit 63 on down shift
    output logic                      qLowIn,
    output logic                      qHighIn
);

    datapathPkg::flagsT liveFlags;
    datapathPkg::flagsT microReg;
    datapathPkg::flagsT machineReg;
    logic [3:0] condSel;
    logic [2:0] shiftLink;
    logic [1:0] carrySel, microSrc, ySel;

    assign condSel   = Iss[datapathPkg::condSelLo +: 4];
    assign shiftLink = Iss[datapathPkg::shiftLinkLo +: 3];
    assign carrySel  = Iss[datapathPkg::carrySelLo +: 2];
    assign microSrc  = Iss[datapathPkg::microSrcLo +: 2];
    assign ySel      = Iss[datapathPkg::ySelLo +: 2];

    assign liveFlags = {C, V, N, Z};

    // Micro status register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            microReg <= '0;
        end else if (!nCEN) begin
            case (microSrc)
                2'd0:    microReg <= liveFlags;
                2'd1:    microReg <= yIn;
                2'd2:    microReg <= machineReg;
                default: microReg <= '0;
            endcase
        end
    end

    // Machine status register, ALU flags only
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            machineReg <= '0;
        end else if (!nCEM) begin
            machineReg <= liveFlags;
        end
    end

    // Condition test
    // Flag bits: 0 zero, 1 negative, 2 overflow, 3 carry
    always_comb begin
        case (condSel)
            4'd0:    CT = microReg[0];
            4'd1:    CT = ~microReg[0];
            4'd2:    CT = microReg[1];
            4'd3:    CT = ~microReg[1];
            4'd4:    CT = microReg[2];
            4'd5:    CT = ~microReg[2];
            4'd6:    CT = microReg[3];
            4'd7:    CT = ~microReg[3];
            4'd8:    CT = microReg[1] ^ microReg[2];                  // Signed less
            4'd9:    CT = microReg[0] | (microReg[1] ^ microReg[2]);  // Signed less or equal
            4'd10:   CT = microReg[3] | microReg[0];
            4'd11:   CT = ~microReg[3] | microReg[0];
            4'd12:   CT = machineReg[0];
            4'd13:   CT = machineReg[1];
            4'd14:   CT = machineReg[2];
            default: CT = machineReg[3];
        endcase
    end

    // Carry out to the ALU carry in
    always_comb begin
        case (carrySel)
            2'd0:    Css = 1'b0;
            2'd1:    Css = 1'b1;
            2'd2:    Css = microReg[3];
            default: Css = ~microReg[3];
        endcase
    end

    // Status bus output
    always_comb begin
        case (ySel)
            2'd0:    yOut = microReg;
            2'd1:    yOut = machineReg;
            2'd2:    yOut = liveFlags;
            default: yOut = '0;
        endcase
    end

    // Shift end fill; high ends matter on down shifts, low ends on up shifts
    always_comb begin
        ramLowIn  = 1'b0;
        ramHighIn = 1'b0;
        qLowIn    = 1'b0;
        qHighIn   = 1'b0;
        if (!nSE) begin
            case (shiftLink)
                3'd1: begin
                    ramLowIn  = 1'b1;
                    ramHighIn = 1'b1;
                    qLowIn    = 1'b1;
                    qHighIn   = 1'b1;
                end
                // RAM rotates on its own, Q gets zeros
                3'd2: begin
                    ramLowIn  = R63;
                    ramHighIn = R0;
                end
                // RAM high, Q low as one 128-bit ring
                3'd3: begin
                    ramLowIn  = Q63;
                    ramHighIn = Q0;
                    qLowIn    = R63;
                    qHighIn   = R0;
                end
                // Sign fill into RAM, RAM bit 0 drops into Q
                3'd4: begin
                    ramHighIn = R63;
                    qHighIn   = R0;
                end
                3'd5: begin
                    ramLowIn  = microReg[3];
                    ramHighIn = microReg[3];
                    qLowIn    = microReg[3];
                    qHighIn   = microReg[3];
                end
                default: ;  // Zero fill, codes 6 and 7 too
            endcase
        end
    end

    // Microprogram must drive every bit every cycle
    assert property (@(posedge clk) disable iff (!arstN) !$isunknown(Iss))
        else $error("statusShift: unknown bits on Iss");

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module datapathTb -f datapath.f -o datapathSim

# The simulator exits nonzero on failure; the log decides the result
./obj_dir/datapathSim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

// File: tb/clockGen.sv
`timescale 1ns/100ps

module clockGen #(
    parameter int periodNs    = 40,
    parameter int resetCycles = 5,
    parameter int skewNs      = 2
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // Reset held over the first edges, released just after one
    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #(skewNs) arstN = 1'b1;
    end

endmodule

// File: tb/datapathTb.sv
`timescale 1ns/100ps

module datapathTb;

    localparam int periodNs     = 40;
    localparam int resetCycles  = 5;
    localparam int skewNs       = 2;
    localparam int directCycles = 16;
    localparam int randomCycles = 600;
    localparam int marginCycles = 10;
    localparam int timeoutNs    =
        (resetCycles + directCycles + randomCycles + marginCycles) * periodNs;

    logic                     clk, arstN;
    datapathPkg::aluInstrT    Ialu;
    datapathPkg::regAddrT     A, B;
    datapathPkg::wordT        D;
    logic                     C0, mode32, nCEM, nCEN;
    datapathPkg::statusInstrT Iss;
    datapathPkg::wordT        oYalu;
    datapathPkg::flagsT       oYss;
    logic                     CT, Css;

    // Reference state: register file, Q, micro and machine status
    datapathPkg::wordT  modelReg [16];
    datapathPkg::wordT  modelQ;
    datapathPkg::flagsT modelMicro, modelMachine;
    logic [31:0]        lfsr;

    clockGen #(.periodNs(periodNs), .resetCycles(resetCycles), .skewNs(skewNs)) clock_i (
        .clk   (clk),
        .arstN (arstN)
    );

    datapath dut_i (
        .clk (clk), .arstN (arstN), .Ialu (Ialu), .A (A), .B (B), .D (D), .C0 (C0),
        .mode32 (mode32), .oYalu (oYalu), .Iss (Iss), .nCEM (nCEM), .nCEN (nCEN),
        .oYss (oYss), .CT (CT), .Css (Css)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic drawBits(input int width, output logic [63:0] value);
        int k;
        value = '0;
        for (k = 0; k < width; k++) begin
            lfsr  = lfsrStep(lfsr);
            value = {value[62:0], lfsr[0]};
        end
    endtask

    task automatic reportFailure(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        if (got !== exp) begin
            reportFailure($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    // 64-bit ALU from the function table, with carries out of bits 31 and 63
    task automatic aluModel(input logic [2:0] func, input datapathPkg::wordT r,
                            input datapathPkg::wordT s, input logic cin,
                            output datapathPkg::wordT f, output logic c32, output logic v32,
                            output logic c64, output logic v64);
        datapathPkg::wordT rr, ss;
        logic [64:0] full;
        logic [63:0] low63;
        logic [32:0] low32;
        logic [31:0] low31;
        rr    = (func == datapathPkg::subR) ? ~r : r;
        ss    = (func == datapathPkg::subS) ? ~s : s;
        full  = {1'b0, rr} + {1'b0, ss} + {64'b0, cin};
        low63 = {1'b0, rr[62:0]} + {1'b0, ss[62:0]} + {63'b0, cin};
        low32 = {1'b0, rr[31:0]} + {1'b0, ss[31:0]} + {32'b0, cin};
        low31 = {1'b0, rr[30:0]} + {1'b0, ss[30:0]} + {31'b0, cin};
        // Logic functions give no carry and no overflow
        c32 = 1'b0;
        v32 = 1'b0;
        c64 = 1'b0;
        v64 = 1'b0;
        case (func)
            datapathPkg::add, datapathPkg::subR, datapathPkg::subS: begin
                f   = full[63:0];
                c64 = full[64];
                v64 = full[64] ^ low63[63];
                c32 = low32[32];
                v32 = low32[32] ^ low31[31];
            end
            datapathPkg::orOp:     f = r | s;
            datapathPkg::andOp:    f = r & s;
            datapathPkg::notRsAnd: f = ~r & s;
            datapathPkg::exor:     f = r ^ s;
            default:               f = ~(r ^ s);
        endcase
    endtask

    task automatic drawStimulus();
        logic [63:0] bits;
        drawBits(9, bits);
        Ialu = bits[8:0];
        drawBits(4, bits);
        A = bits[3:0];
        drawBits(4, bits);
        B = bits[3:0];
        drawBits(64, bits);
        D = bits;
        drawBits(1, bits);
        C0 = bits[0];
        drawBits(1, bits);
        mode32 = bits[0];
        drawBits(13, bits);
        Iss = bits[12:0];
        drawBits(1, bits);
        nCEM = bits[0];
        drawBits(1, bits);
        nCEN = bits[0];
    endtask

    // Expected outputs for this cycle, then the state after the edge
    task automatic evaluateCycle();
        datapathPkg::wordT  aData, r, s, f, yExp, newQ;
        datapathPkg::flagsT live, yssExp, microNext;
        logic       c32, v32, c64, v64, ctExp, cssExp;
        logic       rLow, rHigh, qLow, qHigh;
        logic [3:0] condSel;
        logic [2:0] func, dest, shiftLink;
        logic [1:0] carrySel, microSrc, ySel;
        aData     = modelReg[A];
        func      = Ialu[5:3];
        dest      = Ialu[8:6];
        condSel   = Iss[datapathPkg::condSelLo +: 4];
        shiftLink = Iss[datapathPkg::shiftLinkLo +: 3];
        carrySel  = Iss[datapathPkg::carrySelLo +: 2];
        microSrc  = Iss[datapathPkg::microSrcLo +: 2];
        ySel      = Iss[datapathPkg::ySelLo +: 2];
        // Source pairs R and S
        case (Ialu[2:0])
            3'd0: begin r = aData; s = modelQ; end
            3'd1: begin r = aData; s = modelReg[B]; end
            3'd2: begin r = '0; s = modelQ; end
            3'd3: begin r = '0; s = modelReg[B]; end
            3'd4: begin r = '0; s = aData; end
            3'd5: begin r = D; s = aData; end
            3'd6: begin r = D; s = modelQ; end
            default: begin r = D; s = '0; end
        endcase
        aluModel(func, r, s, C0, f, c32, v32, c64, v64);
        yExp = (dest == datapathPkg::ramA) ? aData : f;
        if (mode32) begin
            live = {c32, v32, f[31], f[31:0] == 32'b0};
        end else begin
            live = {c64, v64, f[63], f == 64'b0};
        end
        case (condSel)
            4'd0, 4'd2, 4'd4, 4'd6: ctExp = modelMicro[condSel[2:1]];
            4'd1, 4'd3, 4'd5, 4'd7: ctExp = ~modelMicro[condSel[2:1]];
            4'd8:  ctExp = modelMicro[1] ^ modelMicro[2];
            4'd9:  ctExp = modelMicro[0] | (modelMicro[1] ^ modelMicro[2]);
            4'd10: ctExp = modelMicro[3] | modelMicro[0];
            4'd11: ctExp = ~modelMicro[3] | modelMicro[0];
            default: ctExp = modelMachine[condSel[1:0]];
        endcase
        cssExp = (carrySel == 2'd0) ? 1'b0 : (carrySel == 2'd1) ? 1'b1 :
                 (carrySel == 2'd2) ? modelMicro[3] : ~modelMicro[3];
        yssExp = (ySel == 2'd0) ? modelMicro : (ySel == 2'd1) ? modelMachine :
                 (ySel == 2'd2) ? live : 4'b0;
        checkValue("oYalu", oYalu, yExp);
        checkValue("oYss", 64'(oYss), 64'(yssExp));
        checkValue("CT", 64'(CT), 64'(ctExp));
        checkValue("Css", 64'(Css), 64'(cssExp));
        // Shift fills, only destinations 4 to 7 shift
        {rLow, rHigh, qLow, qHigh} = 4'b0;
        if (Ialu[8]) begin
            case (shiftLink)
                3'd1: {rLow, rHigh, qLow, qHigh} = 4'b1111;
                3'd2: {rLow, rHigh} = {f[63], f[0]};
                3'd3: {rLow, rHigh, qLow, qHigh} = {modelQ[63], modelQ[0], f[63], f[0]};
                3'd4: {rHigh, qHigh} = {f[63], f[0]};
                3'd5: {rLow, rHigh, qLow, qHigh} = {4{modelMicro[3]}};
                default: ;
            endcase
        end
        newQ = modelQ;
        case (dest)
            datapathPkg::qReg:  newQ = f;
            datapathPkg::ramA, datapathPkg::ramF: modelReg[B] = f;
            datapathPkg::ramQd: begin
                modelReg[B] = {rHigh, f[63:1]};
                newQ        = {qHigh, modelQ[63:1]};
            end
            datapathPkg::ramD:  modelReg[B] = {rHigh, f[63:1]};
            datapathPkg::ramQu: begin
                modelReg[B] = {f[62:0], rLow};
                newQ        = {modelQ[62:0], qLow};
            end
            datapathPkg::ramU:  modelReg[B] = {f[62:0], rLow};
            default: ;
        endcase
        modelQ = newQ;
        // Micro source 2 takes the machine register before this edge
        microNext = modelMicro;
        if (!nCEN) begin
            microNext = (microSrc == 2'd0) ? live : (microSrc == 2'd1) ? D[3:0] :
                        (microSrc == 2'd2) ? modelMachine : 4'b0;
        end
        if (!nCEM) begin
            modelMachine = live;
        end
        modelMicro = microNext;
    endtask

    // Watchdog
    initial begin
        #(timeoutNs);
        reportFailure("timeout, the test sequence did not finish in time");
    end

    initial begin
        lfsr   = 32'habf8_8d17;
        Ialu   = {datapathPkg::nop, datapathPkg::orOp, 3'd4};
        A      = '0;
        B      = '0;
        D      = '0;
        C0     = 1'b0;
        mode32 = 1'b0;
        Iss    = '0;
        nCEM   = 1'b1;
        nCEN   = 1'b1;
        for (int i = 0; i < 16; i++) begin
            modelReg[i] = '0;
        end
        modelQ       = '0;
        modelMicro   = '0;
        modelMachine = '0;
        @(posedge arstN);
        // Each register reads zero through Y, CT with condSel 0 is low
        for (int addr = 0; addr < directCycles; addr++) begin
            @(posedge clk);
            #(skewNs);
            A = datapathPkg::regAddrT'(addr);
            @(negedge clk);
            checkValue("oYalu", oYalu, 64'h0);
            checkValue("CT", 64'(CT), 64'h0);
        end
        for (int cyc = 0; cyc < randomCycles; cyc++) begin
            @(posedge clk);
            #(skewNs);
            drawStimulus();
            @(negedge clk);
            evaluateCycle();
        end
        $display("Testbench passed");
        $finish;
    end

endmodule
